//--- rtl/frv_exec_pkg.sv
// Shared widths, instruction encodings and payload structs of the execute block
`default_nettype none

package frv_exec_pkg;

    // ----------------------------------------
    // Data width
    // ----------------------------------------
    localparam int XLEN = 32;       // Register width
    localparam int XL   = XLEN - 1; // Top bit index

    // Instruction kinds seen by the execute block
    typedef enum logic [1:0] {
        KIND_OP     = 2'd0, // Register-register
        KIND_OP_IMM = 2'd1, // Register-immediate
        KIND_BRANCH = 2'd2  // Conditional branch
    } exec_kind_t;

    // ----------------------------------------
    // funct3 encodings
    // ----------------------------------------
    localparam logic [2:0] F3_ADD  = 3'b000; // add / sub / addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl / sra, picked by f7 bit 30
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ----------------------------------------
    // Payload structs
    // ----------------------------------------
    typedef struct packed {
        exec_kind_t  kind;   // Instruction kind
        logic [2:0]  funct3;
        logic        f7_b30; // sub / sra select
        logic [XL:0] rs1;
        logic [XL:0] rs2;
        logic [XL:0] imm;    // Sign extended by decode
        logic [XL:0] pc;
    } exec_req_t;

    typedef struct packed {
        logic [XL:0] rd_value;  // Writeback value
        logic        rd_wen;    // Writeback enable
        logic        br_taken;
        logic [XL:0] br_target; // Zero unless taken
    } exec_rsp_t;

    // One-hot ALU operation
    typedef struct packed {
        logic op_add;
        logic op_sub;
        logic op_xor;
        logic op_or;
        logic op_and;
        logic op_slt;
        logic op_sltu;
        logic op_srl;
        logic op_sll;
        logic op_sra;
    } alu_op_t;

endpackage

`default_nettype wire

//--- rtl/frv_alu.sv
// Execute stage ALU with shared adder, compares, bitwise logic and a single shifter
`timescale 1ns/1ns
`default_nettype none

module frv_alu (
    input  wire [frv_exec_pkg::XL:0] opr_a,     // Operand A
    input  wire [frv_exec_pkg::XL:0] opr_b,     // Operand B
    input  wire [4:0]                shamt,     // Shift amount
    input  wire frv_exec_pkg::alu_op_t op,      // One-hot operation
    output logic [frv_exec_pkg::XL:0] add_out,  // Raw adder output
    output logic                      cmp_eq,   // opr_a == opr_b
    output logic                      cmp_lt,   // Signed less than
    output logic                      cmp_ltu,  // Unsigned less than
    output logic [frv_exec_pkg::XL:0] result    // Selected result
);

    logic [frv_exec_pkg::XL:0] addsub_rhs;
    logic [frv_exec_pkg::XL:0] addsub_out;
    logic [frv_exec_pkg::XL:0] slt_out;
    logic [frv_exec_pkg::XL:0] bitwise_out;
    logic [frv_exec_pkg::XL:0] shift_in_l;   // opr_a bit reversed
    logic [frv_exec_pkg::XL:0] shift_in;
    logic [frv_exec_pkg::XL:0] shift_out_r;
    logic [frv_exec_pkg::XL:0] shift_out_l;  // Right shift result reversed back
    logic [frv_exec_pkg::XL:0] shift_amask;  // Sign fill for sra
    logic [frv_exec_pkg::XL:0] shift_out;
    logic                      sel_addsub;
    logic                      sel_slt;
    logic                      sel_shift;

    // ----------------------------------------
    // Compares
    // ----------------------------------------
    assign cmp_eq  = (opr_a == opr_b);
    assign cmp_lt  = ($signed(opr_a) < $signed(opr_b));
    assign cmp_ltu = (opr_a < opr_b);

    // ----------------------------------------
    // Add / sub
    // ----------------------------------------
    // Two's complement subtract through inverted rhs plus carry in
    assign addsub_rhs = op.op_sub ? ~opr_b : opr_b;
    assign addsub_out = opr_a + addsub_rhs + {{frv_exec_pkg::XL{1'b0}}, op.op_sub};
    assign add_out    = addsub_out;

    // Set less than, result only in bit 0
    assign slt_out = {{frv_exec_pkg::XL{1'b0}}, op.op_slt ? cmp_lt : cmp_ltu};

    // ----------------------------------------
    // Bitwise
    // ----------------------------------------
    assign bitwise_out = ({frv_exec_pkg::XLEN{op.op_xor}} & (opr_a ^ opr_b)) |
                         ({frv_exec_pkg::XLEN{op.op_or}}  & (opr_a | opr_b)) |
                         ({frv_exec_pkg::XLEN{op.op_and}} & (opr_a & opr_b));

    // ----------------------------------------
    // Shifts
    // ----------------------------------------
    // Left shift reuses the right shifter on reversed bits
    for (genvar i = 0; i < frv_exec_pkg::XLEN; i++) begin : g_rev
        assign shift_in_l[i]  = opr_a[frv_exec_pkg::XL-i];
        assign shift_out_l[i] = shift_out_r[frv_exec_pkg::XL-i];
    end

    assign shift_in    = op.op_sll ? shift_in_l : opr_a;
    assign shift_out_r = shift_in >> shamt;

    // Ones in the vacated top bits when opr_a is negative
    assign shift_amask = opr_a[frv_exec_pkg::XL] ?
                         ~({frv_exec_pkg::XLEN{1'b1}} >> shamt) :
                         {frv_exec_pkg::XLEN{1'b0}};

    assign shift_out = ({frv_exec_pkg::XLEN{op.op_sll}} & shift_out_l) |
                       ({frv_exec_pkg::XLEN{op.op_srl}} & shift_out_r) |
                       ({frv_exec_pkg::XLEN{op.op_sra}} & (shift_out_r | shift_amask));

    // ----------------------------------------
    // Result select
    // ----------------------------------------
    assign sel_addsub = op.op_add | op.op_sub;
    assign sel_slt    = op.op_slt | op.op_sltu;
    assign sel_shift  = op.op_sll | op.op_srl | op.op_sra;

    // Bitwise and shift terms already gated by their own op bits
    assign result = bitwise_out                                     |
                    ({frv_exec_pkg::XLEN{sel_addsub}} & addsub_out) |
                    ({frv_exec_pkg::XLEN{sel_slt}}    & slt_out)    |
                    ({frv_exec_pkg::XLEN{sel_shift}}  & shift_out);

endmodule

`default_nettype wire

//--- rtl/frv_alu_decode.sv
// Maps instruction kind and funct fields onto the one-hot ALU operation
`timescale 1ns/1ns
`default_nettype none

module frv_alu_decode (
    input  wire frv_exec_pkg::exec_kind_t kind,    // Instruction kind
    input  wire [2:0]                     funct3,
    input  wire                           f7_b30,  // sub / sra select
    output frv_exec_pkg::alu_op_t         op,      // One-hot ALU op or all zero
    output logic                          use_imm  // Operand B from immediate
);

    logic is_op;
    logic is_alu;

    assign is_op   = (kind == frv_exec_pkg::KIND_OP);
    assign is_alu  = is_op || (kind == frv_exec_pkg::KIND_OP_IMM);
    assign use_imm = (kind == frv_exec_pkg::KIND_OP_IMM);

    // ----------------------------------------
    // funct3 decode
    // ----------------------------------------
    always_comb begin
        op = '0;
        if (is_alu) begin // Branches leave op clear
            case (funct3)
                frv_exec_pkg::F3_ADD: begin
                    // No subi since bit 30 only counts on register form
                    if (is_op && f7_b30) begin
                        op.op_sub = 1'b1;
                    end else begin
                        op.op_add = 1'b1;
                    end
                end
                frv_exec_pkg::F3_SLL:  op.op_sll  = 1'b1;
                frv_exec_pkg::F3_SLT:  op.op_slt  = 1'b1;
                frv_exec_pkg::F3_SLTU: op.op_sltu = 1'b1;
                frv_exec_pkg::F3_XOR:  op.op_xor  = 1'b1;
                frv_exec_pkg::F3_SR: begin
                    // srai honours bit 30 as well
                    if (f7_b30) begin
                        op.op_sra = 1'b1;
                    end else begin
                        op.op_srl = 1'b1;
                    end
                end
                frv_exec_pkg::F3_OR:   op.op_or   = 1'b1;
                frv_exec_pkg::F3_AND:  op.op_and  = 1'b1;
                default:               op         = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/frv_branch_unit.sv
// Branch condition resolve over ALU compare flags plus target address adder
`timescale 1ns/1ns
`default_nettype none

module frv_branch_unit (
    input  wire frv_exec_pkg::exec_kind_t kind,     // Instruction kind
    input  wire [2:0]                     funct3,   // Branch condition
    input  wire                           cmp_eq,   // From ALU
    input  wire                           cmp_lt,
    input  wire                           cmp_ltu,
    input  wire [frv_exec_pkg::XL:0]      pc,
    input  wire [frv_exec_pkg::XL:0]      imm,      // Sign extended offset
    output logic                          br_taken,
    output logic [frv_exec_pkg::XL:0]     br_target
);

    logic cond; // Condition met, regardless of kind

    // ----------------------------------------
    // Condition select
    // ----------------------------------------
    always_comb begin
        case (funct3)
            frv_exec_pkg::F3_BEQ:  cond = cmp_eq;
            frv_exec_pkg::F3_BNE:  cond = !cmp_eq;
            frv_exec_pkg::F3_BLT:  cond = cmp_lt;
            frv_exec_pkg::F3_BGE:  cond = !cmp_lt;   // ge is not lt
            frv_exec_pkg::F3_BLTU: cond = cmp_ltu;
            frv_exec_pkg::F3_BGEU: cond = !cmp_ltu;
            default:               cond = 1'b0;      // Reserved encodings never taken
        endcase
    end

    assign br_taken = (kind == frv_exec_pkg::KIND_BRANCH) && cond;

    // Target computed always, masked in the response
    assign br_target = pc + imm;

endmodule

`default_nettype wire

//--- rtl/frv_exec_ctrl.sv
// Four-phase req/ack control that latches the request and registers the response
`timescale 1ns/1ns
`default_nettype none

module frv_exec_ctrl (
    input  wire                           g_clk,
    input  wire                           reset,
    input  wire                           req,        // Requester strobe
    input  wire frv_exec_pkg::exec_req_t  req_data,
    output logic                          ack,
    output frv_exec_pkg::exec_rsp_t       rsp_data,
    // Decode side
    output frv_exec_pkg::exec_kind_t      kind,
    output logic [2:0]                    funct3,
    output logic                          f7_b30,
    input  wire                           use_imm,
    // ALU side
    output logic [frv_exec_pkg::XL:0]     opr_a,
    output logic [frv_exec_pkg::XL:0]     opr_b,
    output logic [4:0]                    shamt,
    input  wire [frv_exec_pkg::XL:0]      result,
    // Branch unit side
    output logic [frv_exec_pkg::XL:0]     pc,
    output logic [frv_exec_pkg::XL:0]     imm,
    input  wire                           br_taken,
    input  wire [frv_exec_pkg::XL:0]      br_target
);

    typedef enum logic [1:0] {
        IDLE = 2'd0, // Waiting for req
        EXEC = 2'd1, // One cycle, datapath settles
        ACK  = 2'd2  // Holding ack until req falls
    } state_t;

    state_t                  state;
    frv_exec_pkg::exec_req_t req_q;   // Latched request
    frv_exec_pkg::exec_rsp_t rsp_nxt; // Response to capture in EXEC

    // ----------------------------------------
    // Request register and operand steering
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (state == IDLE && req) begin
            req_q <= req_data; // Accept edge
        end
    end

    assign kind   = req_q.kind;
    assign funct3 = req_q.funct3;
    assign f7_b30 = req_q.f7_b30;
    assign opr_a  = req_q.rs1;
    assign opr_b  = use_imm ? req_q.imm : req_q.rs2;
    assign shamt  = opr_b[4:0]; // Shift count from rs2 or imm low bits
    assign pc     = req_q.pc;
    assign imm    = req_q.imm;

    // Branches write nothing back, non-taken target reads zero
    always_comb begin
        rsp_nxt.rd_value  = result;
        rsp_nxt.rd_wen    = (req_q.kind != frv_exec_pkg::KIND_BRANCH);
        rsp_nxt.br_taken  = br_taken;
        rsp_nxt.br_target = br_taken ? br_target : '0;
    end

    // ----------------------------------------
    // Handshake FSM
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (reset) begin
            state    <= IDLE;
            ack      <= 1'b0;
            rsp_data <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    rsp_data <= rsp_nxt; // Response and ack together
                    ack      <= 1'b1;
                    state    <= ACK;
                end
                ACK: begin
                    if (!req) begin
                        ack   <= 1'b0; // Phase four
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Protocol checks
    // ----------------------------------------
    // ack only answers a request that was present
    a_ack_needs_req : assert property (
        @(posedge g_clk) disable iff (reset) $rose(ack) |-> $past(req)
    ) else $error("ack rose without req");

    // Response held for the whole ack phase
    a_rsp_stable : assert property (
        @(posedge g_clk) disable iff (reset) (ack && $past(ack)) |-> $stable(rsp_data)
    ) else $error("rsp_data changed while ack high");

endmodule

`default_nettype wire

//--- rtl/frv_exec_top.sv
// Integer execute block top joining handshake control, decode, ALU and branch unit
`timescale 1ns/1ns
`default_nettype none

module frv_exec_top (
    input  wire                           g_clk,
    input  wire                           reset,
    input  wire                           req,
    input  wire frv_exec_pkg::exec_req_t  req_data,
    output logic                          ack,
    output frv_exec_pkg::exec_rsp_t       rsp_data
);

    // ----------------------------------------
    // Internal nets
    // ----------------------------------------
    frv_exec_pkg::exec_kind_t  kind;
    logic [2:0]                funct3;
    logic                      f7_b30;
    logic                      use_imm;
    frv_exec_pkg::alu_op_t     op;
    logic [frv_exec_pkg::XL:0] opr_a;
    logic [frv_exec_pkg::XL:0] opr_b;
    logic [4:0]                shamt;
    logic [frv_exec_pkg::XL:0] result;
    logic                      cmp_eq;
    logic                      cmp_lt;
    logic                      cmp_ltu;
    logic [frv_exec_pkg::XL:0] pc;
    logic [frv_exec_pkg::XL:0] imm;
    logic                      br_taken;
    logic [frv_exec_pkg::XL:0] br_target;

    frv_exec_ctrl u_ctrl (
        .g_clk     (g_clk),
        .reset     (reset),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .rsp_data  (rsp_data),
        .kind      (kind),
        .funct3    (funct3),
        .f7_b30    (f7_b30),
        .use_imm   (use_imm),
        .opr_a     (opr_a),
        .opr_b     (opr_b),
        .shamt     (shamt),
        .result    (result),
        .pc        (pc),
        .imm       (imm),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    frv_alu_decode u_decode (
        .kind    (kind),
        .funct3  (funct3),
        .f7_b30  (f7_b30),
        .op      (op),
        .use_imm (use_imm)
    );

    // Adder output unused here, target has its own adder
    frv_alu u_alu (
        .opr_a   (opr_a),
        .opr_b   (opr_b),
        .shamt   (shamt),
        .op      (op),
        .add_out (),
        .cmp_eq  (cmp_eq),
        .cmp_lt  (cmp_lt),
        .cmp_ltu (cmp_ltu),
        .result  (result)
    );

    frv_branch_unit u_branch (
        .kind      (kind),
        .funct3    (funct3),
        .cmp_eq    (cmp_eq),
        .cmp_lt    (cmp_lt),
        .cmp_ltu   (cmp_ltu),
        .pc        (pc),
        .imm       (imm),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

`default_nettype wire

//--- bench/frv_exec_clkgen.sv
// Testbench clock and synchronous reset source for the execute block
`timescale 1ns/1ns
`default_nettype none

module frv_exec_clkgen (
    output logic g_clk,
    output logic reset
);

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk; // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge g_clk);
        #1 reset = 1'b0; // Released just after the eighth edge
    end

endmodule

`default_nettype wire

//--- bench/frv_exec_checker.sv
// Response checker with a reference model of the execute rules and handshake timing
`timescale 1ns/1ns
`default_nettype none

module frv_exec_checker (
    input  wire                          g_clk,
    input  wire                          reset,
    input  wire                          req,
    input  wire frv_exec_pkg::exec_req_t req_data,
    input  wire                          ack,
    input  wire frv_exec_pkg::exec_rsp_t rsp_data,
    input  wire frv_exec_pkg::exec_rsp_t exp_rsp,   // Table value
    input  wire                          use_model, // Predict instead of table
    output int                           n_tests,
    output int                           n_errors
);

    frv_exec_pkg::exec_rsp_t exp_q; // Expected response of the exchange in flight
    frv_exec_pkg::exec_rsp_t rsp_q; // Response seen at ack rise
    logic                    ack_q; // ack one sample back
    logic                    busy;  // Exchange in flight
    logic                    drop_q; // req low while ack high
    int                      wait_n; // Samples from req to ack
    int                      err_mark;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic frv_exec_pkg::exec_rsp_t predict(input frv_exec_pkg::exec_req_t r);
        frv_exec_pkg::exec_rsp_t   p;
        logic [frv_exec_pkg::XL:0] b;
        logic signed [frv_exec_pkg::XL:0] sa;
        logic [4:0]                sh;
        logic                      hit;
        b  = (r.kind == frv_exec_pkg::KIND_OP_IMM) ? r.imm : r.rs2; // Immediate replaces rs2
        sa = r.rs1;
        sh = b[4:0];
        p  = '0;
        hit = 1'b0;
        p.rd_wen = (r.kind != frv_exec_pkg::KIND_BRANCH);
        if (p.rd_wen) begin
            case (r.funct3)
                frv_exec_pkg::F3_ADD: begin
                    if (r.kind == frv_exec_pkg::KIND_OP && r.f7_b30) begin
                        p.rd_value = r.rs1 - b;
                    end else begin
                        p.rd_value = r.rs1 + b; // addi ignores bit 30
                    end
                end
                frv_exec_pkg::F3_SLL:  p.rd_value = r.rs1 << sh;
                frv_exec_pkg::F3_SLT:  p.rd_value = {31'b0, sa < $signed(b)};
                frv_exec_pkg::F3_SLTU: p.rd_value = {31'b0, r.rs1 < b};
                frv_exec_pkg::F3_XOR:  p.rd_value = r.rs1 ^ b;
                frv_exec_pkg::F3_SR: begin
                    if (r.f7_b30) begin
                        p.rd_value = sa >>> sh; // Sign fill
                    end else begin
                        p.rd_value = r.rs1 >> sh;
                    end
                end
                frv_exec_pkg::F3_OR:   p.rd_value = r.rs1 | b;
                default:               p.rd_value = r.rs1 & b;
            endcase
        end else begin
            case (r.funct3)
                frv_exec_pkg::F3_BEQ:  hit = (r.rs1 == r.rs2);
                frv_exec_pkg::F3_BNE:  hit = (r.rs1 != r.rs2);
                frv_exec_pkg::F3_BLT:  hit = ($signed(r.rs1) < $signed(r.rs2));
                frv_exec_pkg::F3_BGE:  hit = ($signed(r.rs1) >= $signed(r.rs2));
                frv_exec_pkg::F3_BLTU: hit = (r.rs1 < r.rs2);
                frv_exec_pkg::F3_BGEU: hit = (r.rs1 >= r.rs2);
                default:               hit = 1'b0;
            endcase
            p.br_taken  = hit;
            p.br_target = hit ? r.pc + r.imm : '0; // Zero when not taken
        end
        return p;
    endfunction

    task automatic fail(input string msg);
        n_errors++;
        $display("ERROR %0t ns: %s", $time, msg);
    endtask

    initial begin
        n_tests  = 0;
        n_errors = 0;
        ack_q    = 1'b0;
        busy     = 1'b0;
        drop_q   = 1'b0;
        wait_n   = 0;
        err_mark = 0;
    end

    // ----------------------------------------
    // Sampling mid cycle, all signals settled
    // ----------------------------------------
    always @(negedge g_clk) begin
        // Cleared outputs in reset and until the first exchange
        if ((reset || (n_tests == 0 && !busy)) && (ack !== 1'b0 || rsp_data !== '0)) begin
            fail("outputs not cleared by reset");
        end
        if (!reset) begin
            if (busy && !ack_q && !ack) begin
                wait_n++;
            end
            if (ack && !ack_q) begin // ack rise
                if (!busy) begin
                    fail("ack rose with no request");
                end else begin
                    wait_n++;
                    if (wait_n != 2) begin
                        fail($sformatf("ack after %0d edges, expected 2", wait_n));
                    end
                    rsp_q = rsp_data;
                    if (rsp_data !== exp_q) begin
                        fail($sformatf("test %0d rd %h/%b br %b/%h, expected rd %h/%b br %b/%h",
                            n_tests + 1, rsp_data.rd_value, rsp_data.rd_wen,
                            rsp_data.br_taken, rsp_data.br_target, exp_q.rd_value,
                            exp_q.rd_wen, exp_q.br_taken, exp_q.br_target));
                    end
                end
            end
            if (ack && ack_q) begin
                if (rsp_data !== rsp_q) fail("rsp_data changed while ack high");
                if (drop_q)             fail("ack still high an edge after req dropped");
            end
            if (!ack && ack_q) begin // Exchange over
                if (!drop_q) fail("ack fell while req still high");
                n_tests++;
                $display("test %0d: %s", n_tests, (n_errors == err_mark) ? "ok" : "FAILED");
                busy = 1'b0;
            end
            drop_q = ack && !req;
            if (!busy && req && !ack) begin // New request
                if (n_tests == 0) begin
                    n_tests++;
                    $display("test %0d reset: %s", n_tests, (n_errors == 0) ? "ok" : "FAILED");
                end
                busy     = 1'b1;
                wait_n   = 0;
                err_mark = n_errors;
                exp_q    = use_model ? predict(req_data) : exp_rsp;
            end
        end
        ack_q = ack;
    end

endmodule

`default_nettype wire

//--- bench/frv_exec_tb.sv
// Testbench top driving table rows through the four-phase req/ack handshake
`timescale 1ns/1ns
`default_nettype none

module frv_exec_tb;

    typedef struct packed {
        frv_exec_pkg::exec_req_t req;   // Request fields
        frv_exec_pkg::exec_rsp_t exp;   // Hand-written result
        logic                    model; // Result left to the checker model
    } row_t;

    logic                    g_clk;
    logic                    reset;
    logic                    req;
    frv_exec_pkg::exec_req_t req_data;
    logic                    ack;
    frv_exec_pkg::exec_rsp_t rsp_data;
    frv_exec_pkg::exec_rsp_t exp_rsp;
    logic                    use_model;
    int                      n_tests;
    int                      n_errors;
    int                      n_timeouts; // Waits that ran out
    int                      seed;
    row_t                    rows[$];

    frv_exec_clkgen clkgen0 (.g_clk(g_clk), .reset(reset));

    frv_exec_top dut0 (
        .g_clk    (g_clk),
        .reset    (reset),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data)
    );

    frv_exec_checker checker0 (
        .g_clk     (g_clk),
        .reset     (reset),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .rsp_data  (rsp_data),
        .exp_rsp   (exp_rsp),
        .use_model (use_model),
        .n_tests   (n_tests),
        .n_errors  (n_errors)
    );

    // ----------------------------------------
    // Table building
    // ----------------------------------------
    task automatic op_row(input logic [2:0] f3, input logic b30, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] val);
        rows.push_back({{frv_exec_pkg::KIND_OP, f3, b30, a, b, 32'h0, 32'h0},
                        {val, 1'b1, 1'b0, 32'h0}, 1'b0});
    endtask

    // rs2 holds junk, the immediate must win
    task automatic imm_row(input logic [2:0] f3, input logic b30, input logic [31:0] a,
                           input logic [31:0] imm, input logic [31:0] val);
        rows.push_back({{frv_exec_pkg::KIND_OP_IMM, f3, b30, a, 32'hdead_beef, imm, 32'h0},
                        {val, 1'b1, 1'b0, 32'h0}, 1'b0});
    endtask

    // All branches sit at pc 0x1000
    task automatic br_row(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] imm, input logic tk, input logic [31:0] tgt);
        rows.push_back({{frv_exec_pkg::KIND_BRANCH, f3, 1'b0, a, b, imm, 32'h1000},
                        {32'h0, 1'b0, tk, tgt}, 1'b0});
    endtask

    task automatic random_row();
        frv_exec_pkg::exec_req_t r;
        logic [31:0]             v;
        v        = $random(seed);
        r.kind   = v[0] ? frv_exec_pkg::KIND_OP_IMM : frv_exec_pkg::KIND_OP;
        r.funct3 = v[3:1];
        r.f7_b30 = v[4];
        r.rs1    = $random(seed);
        r.rs2    = $random(seed);
        v        = $random(seed);
        r.imm    = {{20{v[11]}}, v[11:0]}; // 12-bit immediate, sign extended
        r.pc     = 32'h0;
        rows.push_back({r, 66'h0, 1'b1});
    endtask

    task automatic build_table();
        op_row(frv_exec_pkg::F3_ADD,  1'b0, 32'h5, 32'h7, 32'hc);
        op_row(frv_exec_pkg::F3_ADD,  1'b1, 32'h3, 32'h5, 32'hffff_fffe); // sub wraps
        op_row(frv_exec_pkg::F3_XOR,  1'b0, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0);
        op_row(frv_exec_pkg::F3_OR,   1'b0, 32'hf0f0_0000, 32'h0f0f, 32'hf0f0_0f0f);
        op_row(frv_exec_pkg::F3_AND,  1'b0, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000);
        op_row(frv_exec_pkg::F3_SLT,  1'b0, 32'hffff_ffff, 32'h1, 32'h1);
        op_row(frv_exec_pkg::F3_SLTU, 1'b0, 32'hffff_ffff, 32'h1, 32'h0);
        op_row(frv_exec_pkg::F3_SLL,  1'b0, 32'h1, 32'hffff_ffe4, 32'h10); // Low five bits
        op_row(frv_exec_pkg::F3_SR,   1'b0, 32'h8000_0000, 32'h24, 32'h0800_0000);
        op_row(frv_exec_pkg::F3_SR,   1'b1, 32'h8000_0000, 32'h24, 32'hf800_0000);
        imm_row(frv_exec_pkg::F3_ADD,  1'b1, 32'h64, 32'hffff_ffff, 32'h63); // Still adds
        imm_row(frv_exec_pkg::F3_SR,   1'b1, 32'hffff_ff00, 32'h404, 32'hffff_fff0);
        imm_row(frv_exec_pkg::F3_SR,   1'b0, 32'hffff_ff00, 32'h4, 32'h0fff_fff0);
        imm_row(frv_exec_pkg::F3_SLT,  1'b0, 32'hffff_fffe, 32'hffff_ffff, 32'h1);
        imm_row(frv_exec_pkg::F3_SLTU, 1'b0, 32'h5, 32'hffff_ffff, 32'h1);
        imm_row(frv_exec_pkg::F3_AND,  1'b0, 32'h1234_5678, 32'hff, 32'h78);
        br_row(frv_exec_pkg::F3_BEQ,  32'h55, 32'h55, 32'h40, 1'b1, 32'h1040);
        br_row(frv_exec_pkg::F3_BEQ,  32'h55, 32'h56, 32'h40, 1'b0, 32'h0);
        br_row(frv_exec_pkg::F3_BNE,  32'h55, 32'h56, 32'hffff_fff0, 1'b1, 32'h0ff0);
        br_row(frv_exec_pkg::F3_BNE,  32'h55, 32'h55, 32'hffff_fff0, 1'b0, 32'h0);
        br_row(frv_exec_pkg::F3_BLT,  32'hffff_ffff, 32'h1, 32'h40, 1'b1, 32'h1040);
        br_row(frv_exec_pkg::F3_BLT,  32'h1, 32'hffff_ffff, 32'h40, 1'b0, 32'h0);
        br_row(frv_exec_pkg::F3_BGE,  32'h1, 32'hffff_ffff, 32'h40, 1'b1, 32'h1040);
        br_row(frv_exec_pkg::F3_BGE,  32'hffff_ffff, 32'h1, 32'h40, 1'b0, 32'h0);
        br_row(frv_exec_pkg::F3_BLTU, 32'h1, 32'hffff_ffff, 32'h40, 1'b1, 32'h1040);
        br_row(frv_exec_pkg::F3_BLTU, 32'hffff_ffff, 32'h1, 32'h40, 1'b0, 32'h0);
        br_row(frv_exec_pkg::F3_BGEU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fff0, 1'b1,
               32'h0ff0); // Equal counts as ge
        br_row(frv_exec_pkg::F3_BGEU, 32'h1, 32'hffff_ffff, 32'h40, 1'b0, 32'h0);
        repeat (30) random_row();
    endtask

    // ----------------------------------------
    // Handshake driver, entered 1 ns after an edge
    // ----------------------------------------
    task automatic run_row(input row_t row);
        int n;
        int hold;
        req_data  = row.req;
        exp_rsp   = row.exp;
        use_model = row.model;
        req       = 1'b1;
        n = 0;
        while (ack !== 1'b1 && n < 50) begin
            @(posedge g_clk);
            #1;
            n++;
        end
        if (ack !== 1'b1) begin
            n_timeouts++;
            $display("Timed out after 50 cycles waiting for ack to rise");
        end
        hold = $unsigned($random(seed)) % 6; // Requester holds req a little longer
        repeat (hold) begin
            @(posedge g_clk);
            #1;
        end
        req = 1'b0;
        n = 0;
        while (ack !== 1'b0 && n < 50) begin
            @(posedge g_clk);
            #1;
            n++;
        end
        if (ack !== 1'b0) begin
            n_timeouts++;
            $display("Timed out after 50 cycles waiting for ack to fall");
        end
    endtask

    initial begin
        int n;
        req        = 1'b0;
        req_data   = '0;
        exp_rsp    = '0;
        use_model  = 1'b0;
        n_timeouts = 0;
        seed       = 34;
        build_table();
        n = 0;
        while (reset !== 1'b0 && n < 50) begin
            @(posedge g_clk);
            #1;
            n++;
        end
        if (reset !== 1'b0) begin
            n_timeouts++;
            $display("Timed out waiting for reset to be released");
        end
        @(posedge g_clk); // One idle cycle after reset
        #1;
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        repeat (2) @(posedge g_clk); // Checker closes the last test
        $display("tests %0d, errors %0d, timeouts %0d", n_tests, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/frv_exec_pkg.sv
rtl/frv_alu.sv
rtl/frv_alu_decode.sv
rtl/frv_branch_unit.sv
rtl/frv_exec_ctrl.sv
rtl/frv_exec_top.sv
bench/frv_exec_clkgen.sv
bench/frv_exec_checker.sv
bench/frv_exec_tb.sv
